//--- sources.f
bridge_pkg.sv
asic_pin_regs.sv
config_loader.sv
command_engine.sv
asic_bridge_top.sv
asic_bridge_checker.sv
tb_asic_bridge.sv

//--- Bender.yml
package:
  name: asic_bridge

sources:
  - files:
      - bridge_pkg.sv
      - asic_pin_regs.sv
      - config_loader.sv
      - command_engine.sv
      - asic_bridge_top.sv
  - target: simulation
    files:
      - asic_bridge_checker.sv
      - tb_asic_bridge.sv

//--- tb_asic_bridge.sv
// asic bridge testbench
`timescale 1ns/1ns

module tb_asic_bridge import bridge_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 4000;
    localparam int DATA_WORDS     = 24;

    logic                clk_a_domain;
    logic                reset_n;
    cmd_word_t           cmd_word_i;
    logic                cmd_empty_i;
    logic                cmd_rd_en_o;
    logic [STREAM_W-1:0] data_word_i;
    logic                data_empty_i;
    logic                data_rd_en_o;
    logic                rsp_full_i;
    logic                rsp_wr_en_o;
    cmd_word_t           rsp_word_o;
    logic                stream_ready_i;
    logic                start_ready_i;
    logic                stream_valid_o;
    logic [STREAM_W-1:0] stream_data_o;
    logic                asic_reset_n_o;
    asic_config_t        config_o;

    // fifo models and scoreboards
    cmd_word_t           cmd_q[$];
    logic [STREAM_W-1:0] data_q[$];
    logic [STREAM_W-1:0] stream_exp_q[$];
    cmd_word_t           rsp_q[$];

    logic [31:0] rng_state;
    logic        full_noise;
    int          check_count;
    int          error_count;
    int          cycle_count;

    asic_bridge_top i_dut (.*);

    initial begin
        clk_a_domain = 1'b0;
        forever #4 clk_a_domain = ~clk_a_domain;
    end

    // run limit well above the length of all tests
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk_a_domain);
            cycle_count++;
        end
        $display("timeout: expected responses did not arrive within %0d cycles",
                 TIMEOUT_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] draw_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic check_value(input logic ok, input string what);
        check_count++;
        assert (ok) else begin
            error_count++;
            $display("[ERROR] %0t ns: %s", $time, what);
        end
    endtask

    // head of each fifo is visible while it is not empty
    task automatic refresh_fifos();
        cmd_empty_i  = (cmd_q.size() == 0);
        cmd_word_i   = (cmd_q.size() != 0) ? cmd_q[0] : '0;
        data_empty_i = (data_q.size() == 0);
        data_word_i  = (data_q.size() != 0) ? data_q[0] : '0;
    endtask

    // sample at the falling edge and apply pops after the rising edge
    task automatic step();
        logic                pop_cmd;
        logic                pop_data;
        logic [STREAM_W-1:0] beat;
        @(negedge clk_a_domain);
        pop_cmd  = cmd_rd_en_o;
        pop_data = data_rd_en_o;
        if (rsp_wr_en_o) begin
            check_value(!rsp_full_i, "response written while the fifo is full");
            rsp_q.push_back(rsp_word_o);
        end
        if (stream_valid_o) begin
            check_value(stream_exp_q.size() != 0, "stream beat with no word popped");
            if (stream_exp_q.size() != 0) begin
                beat = stream_exp_q.pop_front();
                check_value(stream_data_o == beat, "stream beat differs from pushed word");
            end
        end
        if (pop_data) begin
            stream_exp_q.push_back(data_q[0]);
        end
        @(posedge clk_a_domain);
        #1;
        if (pop_cmd) begin
            cmd_q.delete(0);
        end
        if (pop_data) begin
            data_q.delete(0);
        end
        rsp_full_i = full_noise && ((draw_random() & 32'h3) == 0);
        refresh_fifos();
    endtask

    task automatic push_command(input logic [OPCODE_W-1:0] op, input logic [PAYLOAD_W-1:0] pl);
        cmd_word_t w;
        w.opcode  = op;
        w.payload = pl;
        cmd_q.push_back(w);
        refresh_fifos();
    endtask

    task automatic wait_response();
        while (rsp_q.size() == 0) begin
            step();
        end
    endtask

    task automatic load_config();
        logic [PAYLOAD_W-1:0] pl [CFG_WORD_COUNT];
        asic_config_t         exp_cfg;
        for (int i = 0; i < CFG_WORD_COUNT; i++) begin
            pl[i] = PAYLOAD_W'(draw_random());
            push_command(OP_CONFIG, pl[i]);
        end
        wait_response();
        repeat (8) step();
        exp_cfg              = '0;
        exp_cfg.mode         = asic_mode_e'(pl[CFG_IDX_MODE][1:0]);
        exp_cfg.train_epochs = pl[CFG_IDX_TRAIN_EPOCHS][15:0];
        exp_cfg.inf_epochs   = pl[CFG_IDX_INF_EPOCHS][15:0];
        exp_cfg.dataset      = dataset_e'(pl[CFG_IDX_DATASET][1:0]);
        exp_cfg.timesteps    = pl[CFG_IDX_TIMESTEPS][15:0];
        exp_cfg.input_size   = pl[CFG_IDX_INPUT_SIZE][15:0];
        exp_cfg.long_stream  = pl[CFG_IDX_LONG_STREAM][0];
        exp_cfg.binary_class = pl[CFG_IDX_BINARY_CLASS][0];
        exp_cfg.loser_enc    = pl[CFG_IDX_LOSER_ENC][0];
        for (int k = 0; k < CUT_COUNT; k++) begin
            exp_cfg.l1_cut[k] = pl[CFG_IDX_L1_CUT_BASE + k][L1_CUT_W-1:0];
            exp_cfg.l2_cut[k] = pl[CFG_IDX_L2_CUT_BASE + k][L2_CUT_W-1:0];
        end
        check_value(config_o == exp_cfg, "configuration record differs from loaded payloads");
        check_value(rsp_q.size() == 1, "expected exactly one response after a load");
        check_value(rsp_q[0].opcode == OP_CONFIG_ACK, "load answered with a wrong opcode");
        rsp_q.delete();
    endtask

    task automatic query_status(input logic level);
        start_ready_i = level;
        repeat (4) step();
        push_command(OP_STATUS, '0);
        wait_response();
        check_value(rsp_q[0].opcode == OP_STATUS, "status query answered with a wrong opcode");
        check_value(rsp_q[0].payload[0] == level, "status answer shows a wrong start-ready");
        rsp_q.delete();
    endtask

    task automatic start_and_finish();
        start_ready_i = 1'b0;
        repeat (4) step();
        push_command(OP_START, '0);
        repeat (10) step();
        check_value(rsp_q.size() == 0, "start answered while the asic was not ready");
        check_value(cmd_q.size() == 1, "start popped while the asic was not ready");
        start_ready_i = 1'b1;
        wait_response();
        check_value(rsp_q[0].opcode == OP_START, "start answered with a wrong opcode");
        rsp_q.delete();
        repeat (3) step();
        start_ready_i = 1'b0;
        repeat (6) step();
        check_value(rsp_q.size() == 0, "completion reported before start-ready rose again");
        start_ready_i = 1'b1;
        wait_response();
        repeat (12) step();
        check_value(rsp_q.size() == 1, "expected exactly one completion report");
        check_value(rsp_q[0].opcode == OP_DONE, "completion reported with a wrong opcode");
        check_value(rsp_q[0].payload[0] == 1'b1, "completion payload bit 0 not set");
        rsp_q.delete();
    endtask

    task automatic stream_data_words();
        logic [STREAM_W-1:0] beat;
        for (int i = 0; i < DATA_WORDS; i++) begin
            beat = STREAM_W'({draw_random(), draw_random(), draw_random()});
            data_q.push_back(beat);
            refresh_fifos();
            step();
            // idle gaps between some of the beats
            if ((draw_random() & 32'h1) != 0) begin
                step();
            end
        end
        while (data_q.size() != 0 || stream_exp_q.size() != 0) begin
            step();
        end
    endtask

    initial begin
        reset_n        = 1'b0;
        cmd_word_i     = '0;
        cmd_empty_i    = 1'b1;
        data_word_i    = '0;
        data_empty_i   = 1'b1;
        rsp_full_i     = 1'b0;
        stream_ready_i = 1'b1;
        start_ready_i  = 1'b0;
        rng_state      = 32'h5b17_db0d;
        full_noise     = 1'b0;
        check_count    = 0;
        error_count    = 0;
        repeat (5) @(posedge clk_a_domain);
        #1;
        reset_n = 1'b1;
        step();
        check_value(!stream_valid_o && !rsp_wr_en_o, "outputs active right after reset");
        full_noise = 1'b1;
        load_config();
        query_status(1'b1);
        query_status(1'b0);
        start_and_finish();
        stream_data_words();
        // a second load shows the word count was cleared by the ack
        load_config();
        repeat (4) step();
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 check_count, error_count, i_dut.i_checker.assert_fail_count);
        if (error_count == 0 && i_dut.i_checker.assert_fail_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- asic_bridge_checker.sv
// bridge timing assertions
`timescale 1ns/1ns

module asic_bridge_checker import bridge_pkg::*; (
    input logic                clk_a_domain,
    input logic                reset_n,
    input logic                cmd_rd_en_o,
    input logic                data_rd_en_o,
    input logic [STREAM_W-1:0] data_word_i,
    input logic                rsp_full_i,
    input logic                rsp_wr_en_o,
    input logic                stream_valid_o,
    input logic [STREAM_W-1:0] stream_data_o,
    input logic                asic_reset_n_o
);

    // failed assertions so far
    int unsigned assert_fail_count = 0;

    // quiet outputs once reset has been seen for a full cycle
    reset_quiet: assert property (@(posedge clk_a_domain)
        !reset_n ##1 !reset_n |-> !cmd_rd_en_o && !data_rd_en_o && !rsp_wr_en_o && !stream_valid_o)
        else begin
            assert_fail_count++;
            $error("bridge outputs active while reset is held");
        end

    reset_passthrough: assert property (@(posedge clk_a_domain) asic_reset_n_o == reset_n)
        else begin
            assert_fail_count++;
            $error("asic reset does not follow reset_n");
        end

    no_write_when_full: assert property (@(posedge clk_a_domain) disable iff (!reset_n)
        rsp_full_i |-> !rsp_wr_en_o)
        else begin
            assert_fail_count++;
            $error("response written while the response fifo is full");
        end

    // popped beat shows up on the pins one cycle later
    beat_forwarded: assert property (@(posedge clk_a_domain) disable iff (!reset_n)
        data_rd_en_o |=> stream_valid_o && (stream_data_o == $past(data_word_i)))
        else begin
            assert_fail_count++;
            $error("data word not forwarded one cycle after its pop");
        end

    no_idle_beat: assert property (@(posedge clk_a_domain) disable iff (!reset_n)
        !data_rd_en_o |=> !stream_valid_o)
        else begin
            assert_fail_count++;
            $error("stream valid without a preceding pop");
        end

endmodule

bind asic_bridge_top asic_bridge_checker i_checker (
    .clk_a_domain   (clk_a_domain),
    .reset_n        (reset_n),
    .cmd_rd_en_o    (cmd_rd_en_o),
    .data_rd_en_o   (data_rd_en_o),
    .data_word_i    (data_word_i),
    .rsp_full_i     (rsp_full_i),
    .rsp_wr_en_o    (rsp_wr_en_o),
    .stream_valid_o (stream_valid_o),
    .stream_data_o  (stream_data_o),
    .asic_reset_n_o (asic_reset_n_o)
);

//--- asic_bridge_top.sv
// spiking asic bridge top level
`timescale 1ns/1ns

module asic_bridge_top import bridge_pkg::*; (
    input  logic                clk_a_domain,
    input  logic                reset_n,

    // host to bridge command fifo
    input  cmd_word_t           cmd_word_i,
    input  logic                cmd_empty_i,
    output logic                cmd_rd_en_o,

    // host to bridge data fifo
    input  logic [STREAM_W-1:0] data_word_i,
    input  logic                data_empty_i,
    output logic                data_rd_en_o,

    // bridge to host response fifo
    input  logic                rsp_full_i,
    output logic                rsp_wr_en_o,
    output cmd_word_t           rsp_word_o,

    // asic pins
    input  logic                stream_ready_i,
    input  logic                start_ready_i,
    output logic                stream_valid_o,
    output logic [STREAM_W-1:0] stream_data_o,
    output logic                asic_reset_n_o,

    // configuration record toward the asic config path
    output asic_config_t        config_o
);

    logic         cfg_accept;
    logic         cfg_ack;
    logic         load_done;
    asic_status_t status;

    // asic reset is not registered
    assign asic_reset_n_o = reset_n;

    asic_pin_regs i_pin_regs (
        .clk_a_domain   (clk_a_domain),
        .reset_n        (reset_n),
        .data_word_i    (data_word_i),
        .data_empty_i   (data_empty_i),
        .data_rd_en_o   (data_rd_en_o),
        .stream_valid_o (stream_valid_o),
        .stream_data_o  (stream_data_o),
        .stream_ready_i (stream_ready_i),
        .start_ready_i  (start_ready_i),
        .status_o       (status)
    );

    config_loader i_config_loader (
        .clk_a_domain (clk_a_domain),
        .reset_n      (reset_n),
        .payload_i    (cmd_word_i.payload),
        .accept_i     (cfg_accept),
        .ack_i        (cfg_ack),
        .load_done_o  (load_done),
        .config_o     (config_o)
    );

    command_engine i_command_engine (
        .clk_a_domain (clk_a_domain),
        .reset_n      (reset_n),
        .cmd_word_i   (cmd_word_i),
        .cmd_empty_i  (cmd_empty_i),
        .cmd_rd_en_o  (cmd_rd_en_o),
        .rsp_full_i   (rsp_full_i),
        .rsp_wr_en_o  (rsp_wr_en_o),
        .rsp_word_o   (rsp_word_o),
        .status_i     (status),
        .load_done_i  (load_done),
        .cfg_accept_o (cfg_accept),
        .cfg_ack_o    (cfg_ack)
    );

endmodule

//--- command_engine.sv
// command decode and response arbitration
`timescale 1ns/1ns

module command_engine import bridge_pkg::*; (
    input  logic         clk_a_domain,
    input  logic         reset_n,

    // host to bridge command fifo
    input  cmd_word_t    cmd_word_i,
    input  logic         cmd_empty_i,
    output logic         cmd_rd_en_o,

    // bridge to host response fifo
    input  logic         rsp_full_i,
    output logic         rsp_wr_en_o,
    output cmd_word_t    rsp_word_o,

    input  asic_status_t status_i,
    input  logic         load_done_i,
    output logic         cfg_accept_o,
    output logic         cfg_ack_o
);

    logic head_valid;
    logic is_config;
    logic is_status;
    logic is_start;
    logic answer_slot;
    logic status_pop;
    logic start_pop;
    logic report_wr;
    logic start_rise;

    logic armed;
    logic report_pending;
    logic start_ready_q;

    assign head_valid = !cmd_empty_i;
    assign is_config  = head_valid && (cmd_word_i.opcode == OP_CONFIG);
    assign is_status  = head_valid && (cmd_word_i.opcode == OP_STATUS);
    assign is_start   = head_valid && (cmd_word_i.opcode == OP_START);

    // config words need no answer, so a full response fifo does not stall them
    assign cfg_accept_o = is_config && !load_done_i;

    // report wins over ack, which wins over a command answer
    assign report_wr   = report_pending && !rsp_full_i;
    assign cfg_ack_o   = load_done_i && !rsp_full_i && !report_pending;
    assign answer_slot = !rsp_full_i && !report_pending && !load_done_i;

    assign status_pop = is_status && answer_slot;
    // start only while the asic says it can take one
    assign start_pop  = is_start && status_i.start_ready && answer_slot;

    assign cmd_rd_en_o = cfg_accept_o || status_pop || start_pop;
    assign rsp_wr_en_o = report_wr || cfg_ack_o || status_pop || start_pop;

    always_comb begin
        rsp_word_o = '0;
        if (report_wr) begin
            rsp_word_o.opcode  = OP_DONE;
            rsp_word_o.payload = PAYLOAD_W'(1);
        end else if (cfg_ack_o) begin
            rsp_word_o.opcode = OP_CONFIG_ACK;
        end else if (status_pop) begin
            rsp_word_o.opcode     = OP_STATUS;
            rsp_word_o.payload[0] = status_i.start_ready;
        end else if (start_pop) begin
            rsp_word_o.opcode = OP_START;
        end
    end

    assign start_rise = status_i.start_ready && !start_ready_q;

    always_ff @(posedge clk_a_domain) begin
        if (!reset_n) begin
            start_ready_q  <= 1'b0;
            armed          <= 1'b0;
            report_pending <= 1'b0;
        end else begin
            start_ready_q <= status_i.start_ready;

            if (report_wr) begin
                armed <= 1'b0;
            end else if (start_pop) begin
                armed <= 1'b1;
            end

            // run finished once start-ready comes back after the start
            if (report_wr) begin
                report_pending <= 1'b0;
            end else if (armed && start_rise) begin
                report_pending <= 1'b1;
            end
        end
    end

endmodule

//--- config_loader.sv
// asic configuration record loader
`timescale 1ns/1ns

module config_loader import bridge_pkg::*; (
    input  logic                 clk_a_domain,
    input  logic                 reset_n,
    input  logic [PAYLOAD_W-1:0] payload_i,
    input  logic                 accept_i,
    input  logic                 ack_i,
    output logic                 load_done_o,
    output asic_config_t         config_o
);

    logic [CFG_IDX_W-1:0] word_idx;
    logic [CFG_IDX_W-1:0] l1_sel;
    logic [CFG_IDX_W-1:0] l2_sel;
    asic_config_t         cfg_q;

    // threshold slot relative to the start of each list
    assign l1_sel = word_idx - CFG_IDX_W'(CFG_IDX_L1_CUT_BASE);
    assign l2_sel = word_idx - CFG_IDX_W'(CFG_IDX_L2_CUT_BASE);

    assign load_done_o = (word_idx == CFG_IDX_W'(CFG_WORD_COUNT));
    assign config_o    = cfg_q;

    always_ff @(posedge clk_a_domain) begin
        if (!reset_n) begin
            word_idx <= '0;
            cfg_q    <= '0;
        end else if (ack_i) begin
            word_idx <= '0;
        end else if (accept_i && !load_done_o) begin
            word_idx <= word_idx + 1'b1;
            // each payload truncated to its field width
            case (word_idx)
                CFG_IDX_MODE:         cfg_q.mode         <= asic_mode_e'(payload_i[1:0]);
                CFG_IDX_TRAIN_EPOCHS: cfg_q.train_epochs <= payload_i[CFG_NUM_W-1:0];
                CFG_IDX_INF_EPOCHS:   cfg_q.inf_epochs   <= payload_i[CFG_NUM_W-1:0];
                CFG_IDX_DATASET:      cfg_q.dataset      <= dataset_e'(payload_i[1:0]);
                CFG_IDX_TIMESTEPS:    cfg_q.timesteps    <= payload_i[CFG_NUM_W-1:0];
                CFG_IDX_INPUT_SIZE:   cfg_q.input_size   <= payload_i[CFG_NUM_W-1:0];
                CFG_IDX_LONG_STREAM:  cfg_q.long_stream  <= payload_i[0];
                CFG_IDX_BINARY_CLASS: cfg_q.binary_class <= payload_i[0];
                CFG_IDX_LOSER_ENC:    cfg_q.loser_enc    <= payload_i[0];
                default: begin
                    // remaining words are the two threshold lists
                    if (word_idx < CFG_IDX_W'(CFG_IDX_L2_CUT_BASE)) begin
                        cfg_q.l1_cut[l1_sel] <= payload_i[L1_CUT_W-1:0];
                    end else begin
                        cfg_q.l2_cut[l2_sel] <= payload_i[L2_CUT_W-1:0];
                    end
                end
            endcase
        end
    end

endmodule

//--- asic_pin_regs.sv
// asic pin register stage
`timescale 1ns/1ns

module asic_pin_regs import bridge_pkg::*; (
    input  logic                clk_a_domain,
    input  logic                reset_n,

    // first-word fall-through data fifo
    input  logic [STREAM_W-1:0] data_word_i,
    input  logic                data_empty_i,
    output logic                data_rd_en_o,

    // stream toward the asic
    output logic                stream_valid_o,
    output logic [STREAM_W-1:0] stream_data_o,

    // ready levels from the asic
    input  logic                stream_ready_i,
    input  logic                start_ready_i,
    output asic_status_t        status_o
);

    // every visible word is taken as there is no back-pressure
    assign data_rd_en_o = !data_empty_i;

    always_ff @(posedge clk_a_domain) begin
        if (!reset_n) begin
            stream_valid_o <= 1'b0;
        end else begin
            stream_valid_o <= data_rd_en_o;
        end
    end

    // beat register loaded only on a pop
    always_ff @(posedge clk_a_domain) begin
        if (data_rd_en_o) begin
            stream_data_o <= data_word_i;
        end
    end

    // one sampling stage on the incoming levels
    always_ff @(posedge clk_a_domain) begin
        if (!reset_n) begin
            status_o <= '0;
        end else begin
            status_o.stream_ready <= stream_ready_i;
            status_o.start_ready  <= start_ready_i;
        end
    end

endmodule

//--- bridge_pkg.sv
// asic bridge shared definitions
package bridge_pkg;

    // command word layout
    localparam int OPCODE_W  = 15;
    localparam int PAYLOAD_W = 17;

    // one beat of the asic input stream
    localparam int STREAM_W = 66;

    // configuration record sizes
    localparam int CUT_COUNT      = 15;
    localparam int L1_CUT_W       = 17;
    localparam int L2_CUT_W       = 16;
    localparam int CFG_NUM_W      = 16;
    localparam int CFG_WORD_COUNT = 39;
    localparam int CFG_IDX_W      = $clog2(CFG_WORD_COUNT + 1);

    // opcodes in both directions between host and bridge
    localparam logic [OPCODE_W-1:0] OP_CONFIG     = 1;
    localparam logic [OPCODE_W-1:0] OP_CONFIG_ACK = 2;
    localparam logic [OPCODE_W-1:0] OP_STATUS     = 7;
    localparam logic [OPCODE_W-1:0] OP_START      = 8;
    localparam logic [OPCODE_W-1:0] OP_DONE       = 9;

    // word position of each field within one configuration load
    localparam int CFG_IDX_MODE         = 0;
    localparam int CFG_IDX_TRAIN_EPOCHS = 1;
    localparam int CFG_IDX_INF_EPOCHS   = 2;
    localparam int CFG_IDX_DATASET      = 3;
    localparam int CFG_IDX_TIMESTEPS    = 4;
    localparam int CFG_IDX_INPUT_SIZE   = 5;
    localparam int CFG_IDX_LONG_STREAM  = 6;
    localparam int CFG_IDX_BINARY_CLASS = 7;
    localparam int CFG_IDX_LOSER_ENC    = 8;
    localparam int CFG_IDX_L1_CUT_BASE  = 9;
    localparam int CFG_IDX_L2_CUT_BASE  = 24;

    typedef enum logic [1:0] {
        MODE_TRAIN_ONLY      = 2'd0,
        MODE_TRAIN_INF_SWEEP = 2'd1,
        MODE_INF_ONLY        = 2'd2
    } asic_mode_e;

    typedef enum logic [1:0] {
        DATASET_GESTURE      = 2'd0,
        DATASET_DIGIT_EVENT  = 2'd1,
        DATASET_SPOKEN_DIGIT = 2'd2
    } dataset_e;

    typedef struct packed {
        logic [PAYLOAD_W-1:0] payload;
        logic [OPCODE_W-1:0]  opcode;
    } cmd_word_t;

    typedef struct packed {
        asic_mode_e                          mode;
        logic [CFG_NUM_W-1:0]                train_epochs;
        logic [CFG_NUM_W-1:0]                inf_epochs;
        dataset_e                            dataset;
        logic [CFG_NUM_W-1:0]                timesteps;
        logic [CFG_NUM_W-1:0]                input_size;
        logic                                long_stream;
        logic                                binary_class;
        logic                                loser_enc;
        logic [CUT_COUNT-1:0][L1_CUT_W-1:0]  l1_cut;
        logic [CUT_COUNT-1:0][L2_CUT_W-1:0]  l2_cut;
    } asic_config_t;

    typedef struct packed {
        logic stream_ready;
        logic start_ready;
    } asic_status_t;

endpackage
